//--- rtl/apb_refill.sv
/*
 * APB read master for line refill
 * four beats per line, error accumulated over the beats
 */

`include "fetch_params.svh"

module apb_refill (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        start_i,
    input  logic [`FETCH_VADDR_W-1:0]   line_addr_i,
    input  logic [`FETCH_INST_W-1:0]    prdata_i,
    input  logic                        pready_i,
    input  logic                        pslverr_i,
    output logic                        psel_o,
    output logic                        penable_o,
    output logic [`FETCH_VADDR_W-1:0]   paddr_o,
    output logic                        done_o,
    output logic                        err_o,
    output fetch_pkg::fetch_line_u      line_o
);

    localparam int BEAT_W = $clog2(`FETCH_LINE_WORDS);

    // fsm encoding
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_SETUP  = 2'd1;
    localparam logic [1:0] ST_ACCESS = 2'd2;

    logic [1:0]                 state_q;
    logic [BEAT_W-1:0]          beat_q;
    logic [`FETCH_VADDR_W-1:0]  addr_q;
    logic                       err_q;
    logic                       done_q;
    fetch_pkg::fetch_line_u     line_q;
    logic                       last_beat;

    assign last_beat = (beat_q == BEAT_W'(`FETCH_LINE_WORDS - 1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
            addr_q  <= '0;
            err_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_SETUP;
                        beat_q  <= '0;
                        addr_q  <= line_addr_i;
                        err_q   <= 1'b0;
                    end
                end
                ST_SETUP: begin
                    state_q <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    // wait states keep everything as is
                    if (pready_i) begin
                        err_q <= err_q | pslverr_i;
                        if (last_beat) begin
                            state_q <= ST_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= ST_SETUP;
                            beat_q  <= beat_q + 1'b1;
                            addr_q  <= addr_q + `FETCH_VADDR_W'(4);
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // beat data into its word of the line
    always_ff @(posedge clk_i) begin
        if (state_q == ST_ACCESS && pready_i) begin
            line_q.raw[beat_q * `FETCH_INST_W +: `FETCH_INST_W] <= prdata_i;
        end
    end

    assign psel_o    = (state_q != ST_IDLE);
    assign penable_o = (state_q == ST_ACCESS);
    assign paddr_o   = addr_q;
    assign done_o    = done_q;
    assign err_o     = err_q;
    assign line_o    = line_q;

    // address held over wait states
    a_paddr_stable: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (penable_o && !pready_i) |=> $stable(paddr_o)
    );

endmodule

//--- rtl/fetch_params.svh
/*
 * sizes for the fetch front end: PC and address widths, reset PC,
 * instruction width, cache line geometry and cache depth
 */

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// PC and implemented virtual address widths
`define FETCH_XLEN        64
`define FETCH_VADDR_W     40

// first PC after reset
`define FETCH_RESET_PC    64'h0000_0000_0000_0200

// instruction word
`define FETCH_INST_W      32

// line geometry, 4 words of 32 bits
`define FETCH_LINE_WORDS  4
`define FETCH_LINE_W      (`FETCH_INST_W * `FETCH_LINE_WORDS)
`define FETCH_OFFSET_W    4

// direct mapped, 8 lines
`define FETCH_LINES       8
`define FETCH_INDEX_W     3
`define FETCH_TAG_W       (`FETCH_VADDR_W - `FETCH_INDEX_W - `FETCH_OFFSET_W)

`endif

//--- rtl/fetch_pkg.sv
/*
 * fetch types: next-PC select, exception causes,
 * instruction word and the cache line union
 */

`include "fetch_params.svh"

package fetch_pkg;

    // source of the next PC
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'd0,
        NEXT_PC_SEL_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP = 2'd2
    } next_pc_sel_t;

    // RISC-V mcause codes, fetch subset only
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } exc_cause_t;

    // one instruction
    typedef logic [`FETCH_INST_W-1:0] inst_t;

    // cache line, seen either as the flat refill word
    // or as four instruction slots picked by PC[3:2]
    typedef union packed {
        logic [`FETCH_LINE_W-1:0]           raw;
        inst_t [`FETCH_LINE_WORDS-1:0]      slot;
    } fetch_line_u;

endpackage

//--- rtl/fetch_top.sv
/*
 * fetch front end top: if_stage, icache and APB refill master
 */

`include "fetch_params.svh"

module fetch_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        stall_i,
    input  fetch_pkg::next_pc_sel_t     next_pc_sel_i,
    input  logic [`FETCH_XLEN-1:0]      pc_jump_i,
    input  logic [`FETCH_INST_W-1:0]    prdata_i,
    input  logic                        pready_i,
    input  logic                        pslverr_i,
    output logic                        fetch_valid_o,
    output logic [`FETCH_XLEN-1:0]      fetch_pc_o,
    output fetch_pkg::inst_t            fetch_inst_o,
    output logic                        ex_valid_o,
    output fetch_pkg::exc_cause_t       ex_cause_o,
    output logic                        psel_o,
    output logic                        penable_o,
    output logic [`FETCH_VADDR_W-1:0]   paddr_o
);

    // fetch stage to cache
    logic                       icache_req;
    logic [`FETCH_VADDR_W-1:0]  icache_vaddr;
    logic                       icache_valid;
    fetch_pkg::fetch_line_u     icache_line;
    logic                       icache_fault;

    // cache to refill master
    logic                       refill_start;
    logic [`FETCH_VADDR_W-1:0]  refill_addr;
    logic                       refill_done;
    logic                       refill_err;
    fetch_pkg::fetch_line_u     refill_line;

    if_stage if_stage_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .stall_i        (stall_i),
        .next_pc_sel_i  (next_pc_sel_i),
        .pc_jump_i      (pc_jump_i),
        .icache_valid_i (icache_valid),
        .icache_line_i  (icache_line),
        .icache_fault_i (icache_fault),
        .icache_req_o   (icache_req),
        .icache_vaddr_o (icache_vaddr),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o),
        .fetch_inst_o   (fetch_inst_o),
        .ex_valid_o     (ex_valid_o),
        .ex_cause_o     (ex_cause_o)
    );

    icache icache_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_i          (icache_req),
        .vaddr_i        (icache_vaddr),
        .refill_done_i  (refill_done),
        .refill_err_i   (refill_err),
        .refill_line_i  (refill_line),
        .valid_o        (icache_valid),
        .line_o         (icache_line),
        .fault_o        (icache_fault),
        .refill_start_o (refill_start),
        .refill_addr_o  (refill_addr)
    );

    apb_refill apb_refill_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .start_i        (refill_start),
        .line_addr_i    (refill_addr),
        .prdata_i       (prdata_i),
        .pready_i       (pready_i),
        .pslverr_i      (pslverr_i),
        .psel_o         (psel_o),
        .penable_o      (penable_o),
        .paddr_o        (paddr_o),
        .done_o         (refill_done),
        .err_o          (refill_err),
        .line_o         (refill_line)
    );

endmodule

//--- rtl/icache.sv
/*
 * direct-mapped instruction cache, 8 lines of 16 bytes
 * combinational lookup, miss register and refill control
 */

`include "fetch_params.svh"

module icache (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        req_i,
    input  logic [`FETCH_VADDR_W-1:0]   vaddr_i,
    input  logic                        refill_done_i,
    input  logic                        refill_err_i,
    input  fetch_pkg::fetch_line_u      refill_line_i,
    output logic                        valid_o,
    output fetch_pkg::fetch_line_u      line_o,
    output logic                        fault_o,
    output logic                        refill_start_o,
    output logic [`FETCH_VADDR_W-1:0]   refill_addr_o
);

    // storage
    logic [`FETCH_TAG_W-1:0]    tag_q   [`FETCH_LINES];
    fetch_pkg::fetch_line_u     data_q  [`FETCH_LINES];
    logic [`FETCH_LINES-1:0]    valid_q;

    // address split
    logic [`FETCH_INDEX_W-1:0]  index;
    logic [`FETCH_TAG_W-1:0]    tag;
    logic [`FETCH_VADDR_W-1:0]  line_base;
    logic [`FETCH_INDEX_W-1:0]  miss_index;

    // refill control
    logic                       pending_q;
    logic                       start_q;
    logic                       fault_q;
    logic [`FETCH_VADDR_W-1:0]  miss_addr_q;

    logic hit;
    logic fault_hit;
    logic miss;

    assign index      = vaddr_i[`FETCH_OFFSET_W +: `FETCH_INDEX_W];
    assign tag        = vaddr_i[`FETCH_VADDR_W-1 -: `FETCH_TAG_W];
    assign line_base  = {vaddr_i[`FETCH_VADDR_W-1:`FETCH_OFFSET_W], {`FETCH_OFFSET_W{1'b0}}};
    assign miss_index = miss_addr_q[`FETCH_OFFSET_W +: `FETCH_INDEX_W];

    // same-cycle lookup
    assign hit = req_i && valid_q[index] && (tag_q[index] == tag);

    // failed line answers once, only for its own address
    assign fault_hit = req_i && fault_q && (line_base == miss_addr_q);
    assign miss      = req_i && !hit && !fault_hit;

    assign valid_o = hit | fault_hit;
    assign fault_o = fault_hit;
    assign line_o  = data_q[index];

    assign refill_start_o = start_q;
    assign refill_addr_o  = miss_addr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q   <= 1'b0;
            start_q     <= 1'b0;
            fault_q     <= 1'b0;
            miss_addr_q <= '0;
            valid_q     <= '0;
        end else begin
            start_q <= 1'b0;
            fault_q <= 1'b0;
            if (refill_done_i) begin
                pending_q <= 1'b0;
                if (refill_err_i) begin
                    fault_q <= 1'b1;
                end else begin
                    valid_q[miss_index] <= 1'b1;
                end
            end else if (miss && !pending_q) begin
                // latch base, start pulses next cycle
                pending_q   <= 1'b1;
                start_q     <= 1'b1;
                miss_addr_q <= line_base;
            end
        end
    end

    // tag and data arrays, written on a clean refill
    always_ff @(posedge clk_i) begin
        if (refill_done_i && !refill_err_i) begin
            tag_q[miss_index]      <= miss_addr_q[`FETCH_VADDR_W-1 -: `FETCH_TAG_W];
            data_q[miss_index].raw <= refill_line_i.raw;
        end
    end

    // one outstanding refill at a time
    a_no_start_while_pending: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        refill_start_o |=> (!refill_start_o until refill_done_i)
    );

endmodule

//--- rtl/if_stage.sv
/*
 * fetch stage: PC register and next-PC mux, fetch exception
 * checks with priority, instruction slot select from the cache line
 */

`include "fetch_params.svh"

module if_stage (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        stall_i,
    input  fetch_pkg::next_pc_sel_t     next_pc_sel_i,
    input  logic [`FETCH_XLEN-1:0]      pc_jump_i,
    input  logic                        icache_valid_i,
    input  fetch_pkg::fetch_line_u      icache_line_i,
    input  logic                        icache_fault_i,
    output logic                        icache_req_o,
    output logic [`FETCH_VADDR_W-1:0]   icache_vaddr_o,
    output logic                        fetch_valid_o,
    output logic [`FETCH_XLEN-1:0]      fetch_pc_o,
    output fetch_pkg::inst_t            fetch_inst_o,
    output logic                        ex_valid_o,
    output fetch_pkg::exc_cause_t       ex_cause_o
);

    logic [`FETCH_XLEN-1:0] pc_q;
    logic [`FETCH_XLEN-1:0] next_pc;

    // exception sources
    logic ex_misaligned;
    logic ex_high_addr;
    logic ex_access_fault;

    // next PC
    always_comb begin
        case (next_pc_sel_i)
            fetch_pkg::NEXT_PC_SEL_PC: begin
                next_pc = pc_q;
            end
            fetch_pkg::NEXT_PC_SEL_PC_4: begin
                // a miss holds the PC until the line arrives
                if (fetch_valid_o) begin
                    next_pc = pc_q + `FETCH_XLEN'(4);
                end else begin
                    next_pc = pc_q;
                end
            end
            fetch_pkg::NEXT_PC_SEL_JUMP: begin
                next_pc = pc_jump_i;
            end
            default: begin
                next_pc = pc_q;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (!stall_i) begin
            pc_q <= next_pc;
        end
    end

    // pc-derived checks, no bus needed
    assign ex_misaligned = |pc_q[1:0];
    assign ex_high_addr  = |pc_q[`FETCH_XLEN-1:`FETCH_VADDR_W];

    // bus error comes back through the cache response
    assign ex_access_fault = ex_high_addr | (icache_valid_i & icache_fault_i);

    // only ask the cache for a clean address
    assign icache_req_o   = !ex_misaligned && !ex_high_addr;
    assign icache_vaddr_o = pc_q[`FETCH_VADDR_W-1:0];

    // misaligned wins over access fault
    always_comb begin
        if (ex_misaligned) begin
            ex_valid_o = 1'b1;
            ex_cause_o = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end else if (ex_access_fault) begin
            ex_valid_o = 1'b1;
            ex_cause_o = fetch_pkg::INSTR_ACCESS_FAULT;
        end else begin
            ex_valid_o = 1'b0;
            ex_cause_o = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end
    end

    // word select inside the line
    assign fetch_inst_o  = icache_line_i.slot[pc_q[3:2]];
    assign fetch_pc_o    = pc_q;
    assign fetch_valid_o = icache_valid_i & ~icache_fault_i;

    // relies on the cache never answering a request that was not made
    a_valid_xor_ex: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(fetch_valid_o && ex_valid_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_fetch_top -f sim.f -o tb_fetch_top
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_fetch_top > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- sim.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/if_stage.sv
rtl/icache.sv
rtl/apb_refill.sv
rtl/fetch_top.sv
tests/tb_apb_mem.sv
tests/tb_fetch_top.sv

//--- tests/tb_apb_mem.sv
/*
 * APB read slave model: word data computed from the address,
 * error window at 0x8000..0x80FF, xorshift wait states, transfer count
 */

`include "fetch_params.svh"

module tb_apb_mem (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic [`FETCH_VADDR_W-1:0]   paddr_i,
    output logic [`FETCH_INST_W-1:0]    prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output int                          xfer_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // every word is its own address scrambled with this key
    localparam logic [31:0] DATA_KEY = 32'h1357_9BDF;

    // slave error window
    localparam logic [`FETCH_VADDR_W-1:0] ERR_LO = `FETCH_VADDR_W'h8000;
    localparam logic [`FETCH_VADDR_W-1:0] ERR_HI = `FETCH_VADDR_W'h80FF;

    logic [31:0] rnd_q;
    int          wait_left;
    logic        completing;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        prdata_o     = '0;
        pready_o     = 1'b0;
        pslverr_o    = 1'b0;
        xfer_count_o = 0;
        rnd_q        = 32'd37;
        wait_left    = 0;
        completing   = 1'b0;
    end

    // mid-cycle look at the handshake that closes on the next edge
    always @(negedge clk_i) begin
        completing = psel_i && penable_i && pready_o;
    end

    // outputs move 5 ns after the edge
    always @(posedge clk_i) begin
        #5;
        if (!rstn_i) begin
            pready_o  = 1'b0;
            pslverr_o = 1'b0;
            wait_left = 0;
        end else begin
            if (completing) begin
                xfer_count_o = xfer_count_o + 1;
            end
            if (psel_i && !penable_i) begin
                // setup phase, draw 0..2 wait states
                rnd_q     = xorshift32(rnd_q);
                wait_left = int'(rnd_q % 3);
                pready_o  = 1'b0;
            end else if (psel_i && penable_i) begin
                if (wait_left == 0) begin
                    pready_o = 1'b1;
                end else begin
                    wait_left = wait_left - 1;
                    pready_o  = 1'b0;
                end
            end else begin
                pready_o = 1'b0;
            end
            prdata_o  = paddr_i[31:0] ^ DATA_KEY;
            pslverr_o = psel_i && (paddr_i >= ERR_LO) && (paddr_i <= ERR_HI);
        end
    end

endmodule

//--- tests/tb_fetch_top.sv
/*
 * testbench for the fetch front end: clock and reset, stimulus table,
 * typed compare tasks, watchdog and the closing verdict
 */

`include "fetch_params.svh"

module tb_fetch_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int N_ENTRIES       = 15;
    localparam int WATCHDOG_CYCLES = N_ENTRIES * 40 + RESET_CYCLES;

    localparam logic [31:0] DATA_KEY = 32'h1357_9BDF;

    logic                           clk;
    logic                           rstn;
    logic                           stall;
    fetch_pkg::next_pc_sel_t        next_pc_sel;
    logic [`FETCH_XLEN-1:0]         pc_jump;
    logic [`FETCH_INST_W-1:0]       prdata;
    logic                           pready;
    logic                           pslverr;
    logic                           fetch_valid;
    logic [`FETCH_XLEN-1:0]         fetch_pc;
    fetch_pkg::inst_t               fetch_inst;
    logic                           ex_valid;
    fetch_pkg::exc_cause_t          ex_cause;
    logic                           psel;
    logic                           penable;
    logic [`FETCH_VADDR_W-1:0]      paddr;
    int                             xfer_count;

    // stimulus and expected values, one row per entry
    fetch_pkg::next_pc_sel_t        tbl_sel    [N_ENTRIES];
    logic [`FETCH_XLEN-1:0]         tbl_jump   [N_ENTRIES];
    logic                           tbl_stall  [N_ENTRIES];
    logic [`FETCH_XLEN-1:0]         tbl_pc     [N_ENTRIES];
    logic                           tbl_ex     [N_ENTRIES];
    fetch_pkg::exc_cause_t          tbl_cause  [N_ENTRIES];
    int                             tbl_xfers  [N_ENTRIES];

    int errors;
    int checks;

    fetch_top fetch_top_inst (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .stall_i        (stall),
        .next_pc_sel_i  (next_pc_sel),
        .pc_jump_i      (pc_jump),
        .prdata_i       (prdata),
        .pready_i       (pready),
        .pslverr_i      (pslverr),
        .fetch_valid_o  (fetch_valid),
        .fetch_pc_o     (fetch_pc),
        .fetch_inst_o   (fetch_inst),
        .ex_valid_o     (ex_valid),
        .ex_cause_o     (ex_cause),
        .psel_o         (psel),
        .penable_o      (penable),
        .paddr_o        (paddr)
    );

    tb_apb_mem apb_mem_inst (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .psel_i         (psel),
        .penable_i      (penable),
        .paddr_i        (paddr),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .xfer_count_o   (xfer_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory word at an aligned address
    function automatic fetch_pkg::inst_t expected_inst(input logic [`FETCH_XLEN-1:0] pc);
        return pc[31:0] ^ DATA_KEY;
    endfunction

    task automatic check_inst(input int idx, input fetch_pkg::inst_t got,
                              input fetch_pkg::inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t entry %0d: instruction %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_pc(input int idx, input logic [`FETCH_XLEN-1:0] got,
                            input logic [`FETCH_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t entry %0d: pc %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_cause(input int idx, input fetch_pkg::exc_cause_t got,
                               input fetch_pkg::exc_cause_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t entry %0d: cause %0d, expected %0d", $time, idx, got, exp);
        end
    endtask

    task automatic check_count(input int idx, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL t=%0t entry %0d: %0d bus transfers, expected %0d",
                     $time, idx, got, exp);
        end
    endtask

    // valid vs exception response
    task automatic check_kind(input int idx, input logic got_valid, input logic got_ex,
                              input logic exp_ex);
        checks++;
        if (got_valid === exp_ex || got_ex !== exp_ex) begin
            errors++;
            $display("FAIL t=%0t entry %0d: valid %b ex %b, expected ex %b",
                     $time, idx, got_valid, got_ex, exp_ex);
        end
    endtask

    // APB master quiet out of reset
    task automatic check_bus_idle(input logic got_psel, input logic got_penable);
        checks++;
        if (got_psel !== 1'b0 || got_penable !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t after reset: psel %b penable %b, expected both low",
                     $time, got_psel, got_penable);
        end
    endtask

    task automatic set_entry(input int idx, input fetch_pkg::next_pc_sel_t sel,
                             input logic [`FETCH_XLEN-1:0] jump, input logic stl,
                             input logic [`FETCH_XLEN-1:0] pc, input logic ex,
                             input fetch_pkg::exc_cause_t cause, input int xfers);
        tbl_sel[idx]   = sel;
        tbl_jump[idx]  = jump;
        tbl_stall[idx] = stl;
        tbl_pc[idx]    = pc;
        tbl_ex[idx]    = ex;
        tbl_cause[idx] = cause;
        tbl_xfers[idx] = xfers;
    endtask

    task automatic fill_table();
        fetch_pkg::exc_cause_t none;
        none = fetch_pkg::INSTR_ADDR_MISALIGNED;
        // first fetch after reset
        set_entry(0, fetch_pkg::NEXT_PC_SEL_PC, 64'h0, 1'b0, 64'h200, 1'b0, none, 4);
        // sequential through line 0x200, then stall, then next line
        set_entry(1, fetch_pkg::NEXT_PC_SEL_PC_4, 64'h0, 1'b0, 64'h204, 1'b0, none, 0);
        set_entry(2, fetch_pkg::NEXT_PC_SEL_PC_4, 64'h0, 1'b0, 64'h208, 1'b0, none, 0);
        set_entry(3, fetch_pkg::NEXT_PC_SEL_PC_4, 64'h0, 1'b0, 64'h20C, 1'b0, none, 0);
        set_entry(4, fetch_pkg::NEXT_PC_SEL_PC_4, 64'h0, 1'b1, 64'h20C, 1'b0, none, 0);
        set_entry(5, fetch_pkg::NEXT_PC_SEL_PC_4, 64'h0, 1'b0, 64'h210, 1'b0, none, 4);
        // 0x1000 shares index 0 with 0x200
        set_entry(6, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h1000, 1'b0, 64'h1000, 1'b0, none, 4);
        set_entry(7, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h1008, 1'b0, 64'h1008, 1'b0, none, 0);
        set_entry(8, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h214, 1'b0, 64'h214, 1'b0, none, 0);
        set_entry(9, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h200, 1'b0, 64'h200, 1'b0, none, 4);
        // pc-derived exceptions, misaligned has priority
        set_entry(10, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h1002, 1'b0, 64'h1002, 1'b1,
                  fetch_pkg::INSTR_ADDR_MISALIGNED, 0);
        set_entry(11, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h0000_0100_0000_0200, 1'b0,
                  64'h0000_0100_0000_0200, 1'b1, fetch_pkg::INSTR_ACCESS_FAULT, 0);
        set_entry(12, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h8000_0000_0000_0201, 1'b0,
                  64'h8000_0000_0000_0201, 1'b1, fetch_pkg::INSTR_ADDR_MISALIGNED, 0);
        // bus error line is never cached, so holding refetches
        set_entry(13, fetch_pkg::NEXT_PC_SEL_JUMP, 64'h8000, 1'b0, 64'h8000, 1'b1,
                  fetch_pkg::INSTR_ACCESS_FAULT, 4);
        set_entry(14, fetch_pkg::NEXT_PC_SEL_PC, 64'h0, 1'b0, 64'h8000, 1'b1,
                  fetch_pkg::INSTR_ACCESS_FAULT, 4);
    endtask

    // starts and ends at a falling edge
    task automatic run_entry(input int idx);
        int base;
        int errs_before;
        base        = xfer_count;
        errs_before = errors;
        @(posedge clk);
        #5;
        next_pc_sel = tbl_sel[idx];
        pc_jump     = tbl_jump[idx];
        stall       = tbl_stall[idx];
        @(posedge clk);
        #5;
        if (tbl_stall[idx]) begin
            // two stalled edges, stall released by the next entry
            @(posedge clk);
            @(negedge clk);
        end else begin
            // one edge took the new pc, now hold it
            next_pc_sel = fetch_pkg::NEXT_PC_SEL_PC;
            @(negedge clk);
            while (!fetch_valid && !ex_valid) begin
                @(negedge clk);
            end
        end
        check_pc(idx, fetch_pc, tbl_pc[idx]);
        check_kind(idx, fetch_valid, ex_valid, tbl_ex[idx]);
        if (tbl_ex[idx]) begin
            check_cause(idx, ex_cause, tbl_cause[idx]);
        end else begin
            check_inst(idx, fetch_inst, expected_inst(tbl_pc[idx]));
        end
        check_count(idx, xfer_count - base, tbl_xfers[idx]);
        if (errors == errs_before) begin
            $display("entry %0d pc %h: ok", idx, fetch_pc);
        end else begin
            $display("entry %0d pc %h: %0d mismatches", idx, fetch_pc, errors - errs_before);
        end
    endtask

    initial begin
        rstn        = 1'b0;
        stall       = 1'b0;
        next_pc_sel = fetch_pkg::NEXT_PC_SEL_PC;
        pc_jump     = '0;
        errors      = 0;
        checks      = 0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rstn = 1'b1;
        @(negedge clk);
        check_bus_idle(psel, penable);
        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("entries %0d, checks %0d, mismatches %0d", N_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // hung refill or lost handshake
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule
